// File: Makefile
TOOL     = verilator
FLAGS    = --binary --timing --assert -j 0
TOP      = tb_snes_loader
FILELIST = verilog.f

.PHONY: simulate clean

simulate:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST)
	@out="$$(./obj_dir/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "all tests passed"

clean:
	rm -rf obj_dir

// File: hw/backup_sector_seq.sv
/*
 * Backup RAM load and save through the SD sector port, 512 bytes per sector.
 * Sector count follows ram_mask and is capped by BSRAM_BITS.
 * sd_rd/sd_wr drop on the rising edge of sd_ack, the sector steps on its falling edge.
 */
`timescale 1ns/1ps

module backup_sector_seq #(
	parameter int BSRAM_BITS = 17
) (
	input  logic        clk_sys,
	input  logic        RESET,
	input  logic        cart_download,
	input  logic        img_mounted,
	input  logic        img_readonly,
	input  logic [63:0] img_size,
	input  logic [23:0] ram_mask,
	input  logic        osd_status,
	input  logic        autosave,
	input  logic        load_req,
	input  logic        save_req,
	input  logic        bsram_we,
	input  logic        sd_ack,
	output logic [31:0] sd_lba,
	output logic        sd_rd,
	output logic        sd_wr,
	output logic        bk_ena,
	output logic        bk_pending,
	output logic        bk_busy,
	output logic        bk_loading
);

	localparam logic [31:0] MAX_SECTOR = (32'd1 << (BSRAM_BITS - 9)) - 32'd1;

	logic old_dl;
	logic old_load;
	logic old_save;
	logic old_ack;
	logic save_cond;
	logic load_go;
	logic save_go;
	logic dl_done_go;
	logic last_sector;

	// Autosave fires when the OSD opens with unsaved writes
	assign save_cond   = save_req | (bk_pending & osd_status & autosave);
	assign load_go     = load_req & bk_ena & ~old_load;
	assign save_go     = save_cond & bk_ena & ~old_save;
	assign dl_done_go  = old_dl & ~cart_download & (|img_size) & bk_ena;
	assign last_sector = (sd_lba >= 32'(ram_mask[23:9])) || (sd_lba == MAX_SECTOR);

	always_ff @(posedge clk_sys) begin
		if (RESET) begin
			old_dl     <= 1'b0;
			old_load   <= 1'b0;
			old_save   <= 1'b0;
			old_ack    <= 1'b0;
			bk_ena     <= 1'b0;
			bk_pending <= 1'b0;
			bk_busy    <= 1'b0;
			bk_loading <= 1'b0;
			sd_rd      <= 1'b0;
			sd_wr      <= 1'b0;
			sd_lba     <= '0;
		end else begin
			old_dl   <= cart_download;
			old_load <= load_req & bk_ena;
			old_save <= save_cond & bk_ena;
			old_ack  <= sd_ack;

			// Image is mounted by the time the download runs
			if (~old_dl & cart_download)
				bk_ena <= 1'b0;
			if (cart_download & img_mounted & ~img_readonly)
				bk_ena <= |ram_mask;

			if (bk_ena & ~osd_status & bsram_we)
				bk_pending <= 1'b1;
			else if (bk_busy | ~bk_ena)
				bk_pending <= 1'b0;

			if (~old_ack & sd_ack) begin
				sd_rd <= 1'b0;
				sd_wr <= 1'b0;
			end

			if (!bk_busy) begin
				if (load_go | save_go | dl_done_go) begin
					bk_busy    <= 1'b1;
					bk_loading <= load_go | dl_done_go;
					sd_lba     <= '0;
					sd_rd      <= load_go | dl_done_go;
					sd_wr      <= ~(load_go | dl_done_go);
				end
			end else if (old_ack & ~sd_ack) begin
				if (last_sector) begin
					bk_busy    <= 1'b0;
					bk_loading <= 1'b0;
				end else begin
					sd_lba <= sd_lba + 32'd1;
					sd_rd  <= bk_loading;
					sd_wr  <= ~bk_loading;
				end
			end
		end
	end

endmodule

// File: hw/cart_header_decode.sv
/*
 * Cartridge header detection from the download stream.
 * Sizes come from word 0 in auto mode, or from the internal header in forced
 * mappings. Region is frozen while a cartridge is downloading.
 */
`timescale 1ns/1ps

module cart_header_decode (
	input  logic                         clk_sys,
	input  logic                         RESET,
	ioctl_if.decoder                     io,
	input  snes_loader_pkg::header_mode_e header_mode,
	input  logic [1:0]                   region_mode,
	output logic                         cart_download,
	output logic [7:0]                   rom_type,
	output logic [23:0]                  rom_mask,
	output logic [23:0]                  ram_mask,
	output logic                         pal
);

	import snes_loader_pkg::*;

	ioctl_word_u word;
	logic        hdr_wr;
	logic        hdr_forced;
	logic [24:0] hdr_base;
	logic [3:0]  rom_size;
	logic [3:0]  ram_size;
	logic [3:0]  rom_size_nxt;
	logic [3:0]  ram_size_nxt;
	logic        rom_region;

	assign word          = io.dout;
	assign cart_download = io.download & (io.index[5:0] == IDX_CART[5:0]);
	assign hdr_wr        = cart_download & io.wr;

	// Header word location for the forced mappings
	always_comb begin
		hdr_forced = 1'b1;
		case (header_mode)
			MODE_LOROM:   hdr_base = HDR_LOROM;
			MODE_HIROM:   hdr_base = HDR_HIROM;
			MODE_EXHIROM: hdr_base = HDR_EXHIROM;
			default: begin
				hdr_base   = '0;
				hdr_forced = 1'b0;
			end
		endcase
	end

	// Sizes after this word, so the masks follow one cycle later
	always_comb begin
		rom_size_nxt = rom_size;
		ram_size_nxt = ram_size;
		if (io.addr == '0) begin
			rom_size_nxt = 4'hC;
			ram_size_nxt = 4'h0;
			if (header_mode == MODE_AUTO && word.first[7:0] != 8'h00) begin
				rom_size_nxt = word.first.rom_size;
				ram_size_nxt = word.first.ram_size;
			end
		end
		if (hdr_forced && io.addr == hdr_base)
			rom_size_nxt = word.info.size_hi;
		if (hdr_forced && io.addr == hdr_base + 25'd2)
			ram_size_nxt = word.info.size_lo;
	end

	always_ff @(posedge clk_sys) begin
		if (RESET) begin
			rom_size   <= '0;
			ram_size   <= '0;
			rom_type   <= '0;
			rom_mask   <= '0;
			ram_mask   <= '0;
			rom_region <= 1'b0;
			pal        <= 1'b0;
		end else begin
			if (hdr_wr) begin
				rom_size <= rom_size_nxt;
				ram_size <= ram_size_nxt;
				rom_mask <= (24'd1024 << rom_size_nxt) - 24'd1;
				ram_mask <= (ram_size_nxt != 4'h0) ? (24'd1024 << ram_size_nxt) - 24'd1 : 24'd0;
				if (io.addr == '0) begin
					case (header_mode)
						MODE_NONE, MODE_LOROM: rom_type <= 8'd0;
						MODE_HIROM:            rom_type <= 8'd1;
						MODE_EXHIROM:          rom_type <= 8'd2;
						default:               rom_type <= word.first.rom_type;
					endcase
				end
				// Region flag sits in bit 8 of the second word
				if (io.addr == 25'd2)
					rom_region <= word.info.size_hi[0];
			end
			if (!cart_download)
				pal <= (region_mode == 2'd0) ? rom_region : region_mode[1];
		end
	end

endmodule

// File: hw/cheat_code_assembler.sv
/*
 * Builds 129-bit cheat codes from eight-word records.
 * Bit 128 strobes for one cycle once offset 14 has been written.
 */
`timescale 1ns/1ps

module cheat_code_assembler (
	input  logic                            clk_sys,
	input  logic                            RESET,
	ioctl_if.decoder                        io,
	input  logic                            cart_download,
	output logic [snes_loader_pkg::CHEAT_W-1:0] gg_code,
	output logic                            gg_reset
);

	import snes_loader_pkg::*;

	logic               code_wr;
	logic               gg_strobe;
	logic [CHEAT_W-2:0] gg_data;

	assign code_wr  = io.download & (io.index == IDX_CODE) & io.wr;
	assign gg_reset = cart_download | (code_wr & (io.addr == '0));
	assign gg_code  = {gg_strobe, gg_data};

	// Layout {flags, address, compare, replace}, low word first per field
	always_ff @(posedge clk_sys) begin
		if (code_wr) begin
			case (io.addr[3:0])
				4'd0:    gg_data[111:96]  <= io.dout;
				4'd2:    gg_data[127:112] <= io.dout;
				4'd4:    gg_data[79:64]   <= io.dout;
				4'd6:    gg_data[95:80]   <= io.dout;
				4'd8:    gg_data[47:32]   <= io.dout;
				4'd10:   gg_data[63:48]   <= io.dout;
				4'd12:   gg_data[15:0]    <= io.dout;
				4'd14:   gg_data[31:16]   <= io.dout;
				default: ;
			endcase
		end
	end

	always_ff @(posedge clk_sys) begin
		if (RESET)
			gg_strobe <= 1'b0;
		else
			gg_strobe <= code_wr & (io.addr[3:0] == 4'd14);
	end

endmodule

// File: hw/core_reset_gen.sv
/*
 * Core reset and refresh at quarter clock rate, plus the activity LED.
 * Reset release lags the sources by 1 to 4 cycles.
 */
`timescale 1ns/1ps

module core_reset_gen (
	input  logic clk_sys,
	input  logic RESET,
	input  logic user_reset,
	input  logic cart_download,
	input  logic bk_loading,
	input  logic fill_wr,
	input  logic bk_pending,
	input  logic autosave,
	output logic core_reset_n,
	output logic refresh,
	output logic led_user
);

	logic [1:0] div;
	logic       reset_any;

	// Core is held while anything rewrites its memories
	assign reset_any = RESET | user_reset | cart_download | bk_loading | fill_wr;
	assign led_user  = cart_download | (autosave & bk_pending);

	always_ff @(posedge clk_sys) begin
		if (RESET) begin
			div          <= '0;
			refresh      <= 1'b0;
			core_reset_n <= 1'b0;
		end else begin
			div     <= div + 2'd1;
			refresh <= (div == 2'd0);
			if (div == 2'd2)
				core_reset_n <= ~reset_any;
		end
	end

endmodule

// File: hw/ioctl_if.sv
/*
 * Download stream from the host.
 * A word is valid only in the cycle where wr is high.
 */
`timescale 1ns/1ps

interface ioctl_if;

	logic        download;
	logic [7:0]  index;
	logic [24:0] addr;
	logic [15:0] dout;
	logic        wr;

	// Host side
	modport producer (output download, index, addr, dout, wr);

	// Stream decoders and the RAM clear
	modport decoder (input download, index, addr, dout, wr);

endinterface

// File: hw/snes_loader_pkg.sv
/*
 * Shared constants and types for the SNES cartridge loader.
 * Header addresses include the 512-byte copier header and are byte addresses
 * within the 25-bit download address space.
 */
package snes_loader_pkg;

	// Download stream indices
	localparam logic [7:0] IDX_CART = 8'h00;
	localparam logic [7:0] IDX_CODE = 8'hFF;

	// ========================================================================
	// Internal header locations
	// ========================================================================
	localparam logic [24:0] COPIER_HDR  = 25'd512;
	localparam logic [24:0] HDR_LOROM   = 25'h007FD6 + COPIER_HDR;
	localparam logic [24:0] HDR_HIROM   = 25'h00FFD6 + COPIER_HDR;
	localparam logic [24:0] HDR_EXHIROM = 25'h40FFD6 + COPIER_HDR;

	// Header mode selection as set from the OSD
	typedef enum logic [2:0] {
		MODE_AUTO    = 3'd0,
		MODE_NONE    = 3'd1,
		MODE_LOROM   = 3'd2,
		MODE_HIROM   = 3'd3,
		MODE_EXHIROM = 3'd4
	} header_mode_e;

	// Fill patterns, pairs hold {pattern when clear, pattern when set}
	localparam logic [15:0] FILL_9966 = 16'h9966;
	localparam logic [15:0] FILL_00FF = 16'h00FF;
	localparam logic [7:0]  FILL_55   = 8'h55;
	localparam logic [7:0]  FILL_FF   = 8'hFF;

	// One download word, seen as the first word or as a header size word
	typedef union packed {
		struct packed {
			logic [7:0] rom_type;
			logic [3:0] ram_size;
			logic [3:0] rom_size;
		} first;
		struct packed {
			logic [3:0] unused_hi;
			logic [3:0] size_hi;
			logic [3:0] unused_lo;
			logic [3:0] size_lo;
		} info;
	} ioctl_word_u;

	localparam int CHEAT_W = 129;

endpackage

// File: hw/snes_loader_top.sv
/*
 * Cartridge loader top level with plain ports.
 * Memories are external; only fill and sector requests leave this block.
 */
`timescale 1ns/1ps

module snes_loader_top #(
	parameter int FILL_BITS  = 17,
	parameter int BSRAM_BITS = 17
) (
	input  logic                                clk_sys,
	input  logic                                RESET,
	// Download stream
	input  logic                                ioctl_download,
	input  logic [7:0]                          ioctl_index,
	input  logic [24:0]                         ioctl_addr,
	input  logic [15:0]                         ioctl_dout,
	input  logic                                ioctl_wr,
	// Options
	input  snes_loader_pkg::header_mode_e        header_mode,
	input  logic [1:0]                          region_mode,
	input  logic [1:0]                          wram_init,
	input  logic                                user_reset,
	input  logic                                autosave,
	input  logic                                osd_status,
	input  logic                                load_req,
	input  logic                                save_req,
	input  logic                                bsram_we,
	// Image and SD sector port
	input  logic                                img_mounted,
	input  logic                                img_readonly,
	input  logic [63:0]                         img_size,
	input  logic                                sd_ack,
	output logic [31:0]                         sd_lba,
	output logic                                sd_rd,
	output logic                                sd_wr,
	// Results
	output logic [7:0]                          rom_type,
	output logic [23:0]                         rom_mask,
	output logic [23:0]                         ram_mask,
	output logic                                pal,
	output logic [snes_loader_pkg::CHEAT_W-1:0] gg_code,
	output logic                                gg_reset,
	output logic [FILL_BITS-1:0]                fill_addr,
	output logic                                fill_wr,
	output logic [7:0]                          fill_data,
	output logic                                bk_ena,
	output logic                                bk_pending,
	output logic                                bk_busy,
	output logic                                bk_loading,
	output logic                                core_reset_n,
	output logic                                refresh,
	output logic                                led_user
);

	logic cart_download;

	ioctl_if io ();

	assign io.download = ioctl_download;
	assign io.index    = ioctl_index;
	assign io.addr     = ioctl_addr;
	assign io.dout     = ioctl_dout;
	assign io.wr       = ioctl_wr;

	// ========================================================================
	// Decode
	// ========================================================================
	cart_header_decode u_cart_header_decode (
		.clk_sys(clk_sys), .RESET(RESET), .io(io.decoder),
		.header_mode(header_mode), .region_mode(region_mode),
		.cart_download(cart_download), .rom_type(rom_type),
		.rom_mask(rom_mask), .ram_mask(ram_mask), .pal(pal)
	);

	cheat_code_assembler u_cheat_code_assembler (
		.clk_sys(clk_sys), .RESET(RESET), .io(io.decoder),
		.cart_download(cart_download), .gg_code(gg_code), .gg_reset(gg_reset)
	);

	// ========================================================================
	// Execute
	// ========================================================================
	wram_clear_seq #(.FILL_BITS(FILL_BITS)) u_wram_clear_seq (
		.clk_sys(clk_sys), .RESET(RESET), .io(io.decoder),
		.cart_download(cart_download), .wram_init(wram_init),
		.fill_addr(fill_addr), .fill_wr(fill_wr), .fill_data(fill_data)
	);

	backup_sector_seq #(.BSRAM_BITS(BSRAM_BITS)) u_backup_sector_seq (
		.clk_sys(clk_sys), .RESET(RESET), .cart_download(cart_download),
		.img_mounted(img_mounted), .img_readonly(img_readonly), .img_size(img_size),
		.ram_mask(ram_mask), .osd_status(osd_status), .autosave(autosave),
		.load_req(load_req), .save_req(save_req), .bsram_we(bsram_we),
		.sd_ack(sd_ack), .sd_lba(sd_lba), .sd_rd(sd_rd), .sd_wr(sd_wr),
		.bk_ena(bk_ena), .bk_pending(bk_pending), .bk_busy(bk_busy),
		.bk_loading(bk_loading)
	);

	// ========================================================================
	// Result
	// ========================================================================
	core_reset_gen u_core_reset_gen (
		.clk_sys(clk_sys), .RESET(RESET), .user_reset(user_reset),
		.cart_download(cart_download), .bk_loading(bk_loading), .fill_wr(fill_wr),
		.bk_pending(bk_pending), .autosave(autosave),
		.core_reset_n(core_reset_n), .refresh(refresh), .led_user(led_user)
	);

endmodule

// File: hw/wram_clear_seq.sv
/*
 * Clears work RAM once at the start of every cartridge download.
 * Fill runs for 2^FILL_BITS cycles; FILL_BITS must be at least 10.
 */
`timescale 1ns/1ps

module wram_clear_seq #(
	parameter int FILL_BITS = 17
) (
	input  logic                 clk_sys,
	input  logic                 RESET,
	ioctl_if.decoder             io,
	input  logic                 cart_download,
	input  logic [1:0]           wram_init,
	output logic [FILL_BITS-1:0] fill_addr,
	output logic                 fill_wr,
	output logic [7:0]           fill_data
);

	import snes_loader_pkg::*;

	logic dl_prev;
	logic start;

	// New transfer, cart_download already qualifies the index
	assign start = cart_download & ~dl_prev;

	always_ff @(posedge clk_sys) begin
		if (RESET) begin
			dl_prev   <= 1'b0;
			fill_wr   <= 1'b0;
			fill_addr <= '0;
		end else begin
			dl_prev <= io.download;
			if (start)
				fill_wr <= 1'b1;
			if (&fill_addr)
				fill_wr <= 1'b0;
			fill_addr <= fill_wr ? fill_addr + 1'b1 : '0;
		end
	end

	// Power-on patterns of the various console revisions
	always_comb begin
		case (wram_init)
			2'd0:    fill_data = (fill_addr[8] ^ fill_addr[2]) ? FILL_9966[7:0] : FILL_9966[15:8];
			2'd1:    fill_data = (fill_addr[9] ^ fill_addr[0]) ? FILL_00FF[7:0] : FILL_00FF[15:8];
			2'd2:    fill_data = FILL_55;
			default: fill_data = FILL_FF;
		endcase
	end

endmodule

// File: test/tb_snes_loader.sv
/*
 * Testbench for the cartridge loader, built with a 10-bit clear counter.
 * An SD host model answers every sector request with a two-cycle ack.
 * The run is bounded by a cycle watchdog.
 */
`timescale 1ns/1ps

module tb_snes_loader;

	import snes_loader_pkg::*;

	localparam int FILL_BITS   = 10;
	localparam int FILL_LEN    = 1 << FILL_BITS;
	// Four RAM clears dominate, plus cheat, header and two backup passes
	localparam int CYCLE_LIMIT = 6000;
	// Sectors covered by a ram_mask of 0x1FFF
	localparam int SECTORS     = (24'h1FFF >> 9) + 1;

	logic clk_sys;
	logic RESET;
	logic ioctl_download;
	logic [7:0] ioctl_index;
	logic [24:0] ioctl_addr;
	logic [15:0] ioctl_dout;
	logic ioctl_wr;
	header_mode_e header_mode;
	logic [1:0] region_mode;
	logic [1:0] wram_init;
	logic user_reset;
	logic autosave;
	logic osd_status;
	logic load_req;
	logic save_req;
	logic bsram_we;
	logic img_mounted;
	logic img_readonly;
	logic [63:0] img_size;
	logic sd_ack;
	logic [31:0] sd_lba;
	logic sd_rd;
	logic sd_wr;
	logic [7:0] rom_type;
	logic [23:0] rom_mask;
	logic [23:0] ram_mask;
	logic pal;
	logic [CHEAT_W-1:0] gg_code;
	logic gg_reset;
	logic [FILL_BITS-1:0] fill_addr;
	logic fill_wr;
	logic [7:0] fill_data;
	logic bk_ena;
	logic bk_pending;
	logic bk_busy;
	logic bk_loading;
	logic core_reset_n;
	logic refresh;
	logic led_user;

	integer seed;
	int errors;
	int cycles;
	int run_len;
	int fill_runs;
	int refresh_gap;
	logic [31:0] lba_log[$];
	logic write_log[$];
	logic load_log[$];
	logic [15:0] cheat_w [8];
	logic [15:0] word2;

	snes_loader_top #(.FILL_BITS(FILL_BITS)) u_snes_loader_top (.*);

	initial begin
		clk_sys = 1'b0;
		forever #50 clk_sys = ~clk_sys;
	end

	task automatic check_value(input string name, input logic [127:0] got,
		input logic [127:0] exp);
		assert (got === exp) else begin
			errors++;
			$display("FAIL %s: got %0h, expected %0h", name, got, exp);
		end
	endtask

	function automatic logic [23:0] size_mask(input logic [3:0] size);
		return (24'd1024 << size) - 24'd1;
	endfunction

	function automatic logic [7:0] fill_pattern(input logic [1:0] mode,
		input logic [FILL_BITS-1:0] a);
		case (mode)
			2'd0:    return (a[8] ^ a[2]) ? 8'h66 : 8'h99;
			2'd1:    return (a[9] ^ a[0]) ? 8'hFF : 8'h00;
			2'd2:    return 8'h55;
			default: return 8'hFF;
		endcase
	endfunction

	task automatic begin_download(input logic [7:0] idx);
		@(posedge clk_sys);
		ioctl_download <= 1'b1;
		ioctl_index    <= idx;
	endtask

	task automatic end_download();
		@(posedge clk_sys);
		ioctl_download <= 1'b0;
	endtask

	task automatic drive_word(input logic [24:0] a, input logic [15:0] d);
		@(posedge clk_sys);
		ioctl_addr <= a;
		ioctl_dout <= d;
		ioctl_wr   <= 1'b1;
		@(posedge clk_sys);
		ioctl_wr   <= 1'b0;
	endtask

	task automatic wait_fill_done();
		while (fill_wr !== 1'b1)
			@(negedge clk_sys);
		while (fill_wr === 1'b1)
			@(negedge clk_sys);
	endtask

	task automatic wait_backup_done();
		while (bk_busy !== 1'b1)
			@(negedge clk_sys);
		while (bk_busy === 1'b1)
			@(negedge clk_sys);
	endtask

	// Logged sectors must run 0 to SECTORS-1, all of one direction
	task automatic check_sectors(input logic is_save);
		check_value("sector count", 128'(lba_log.size()), 128'(SECTORS));
		foreach (lba_log[i]) begin
			check_value("sd_lba", 128'(lba_log[i]), 128'(i));
			check_value("sd_wr", 128'(write_log[i]), 128'(is_save));
			check_value("bk_loading", 128'(load_log[i]), 128'(!is_save));
		end
		lba_log.delete();
		write_log.delete();
		load_log.delete();
	endtask

	// ========================================================================
	// SD host model and monitors
	// ========================================================================
	initial begin
		forever begin
			@(posedge clk_sys);
			if (!RESET && (sd_rd || sd_wr)) begin
				lba_log.push_back(sd_lba);
				write_log.push_back(sd_wr);
				load_log.push_back(bk_loading);
				sd_ack <= 1'b1;
				repeat (2) @(posedge clk_sys);
				sd_ack <= 1'b0;
				@(posedge clk_sys);
			end
		end
	end

	// Strobe bit of a cheat code lasts one cycle
	assert property (@(posedge clk_sys) disable iff (RESET) gg_code[128] |=> !gg_code[128])
		else begin
			errors++;
			$display("gg_code strobe stayed high for more than one cycle");
		end

	always @(negedge clk_sys) begin
		if (!RESET) begin
			check_value("gg_reset", 128'(gg_reset), 128'((ioctl_download &&
				ioctl_index[5:0] == 6'd0) || (ioctl_download && ioctl_index == 8'hFF &&
				ioctl_wr && ioctl_addr == 25'd0)));
			if (fill_wr === 1'b1) begin
				check_value("fill_addr", 128'(fill_addr), 128'(run_len));
				check_value("fill_data", 128'(fill_data), 128'(fill_pattern(wram_init, fill_addr)));
				// Core reset sampling lags by up to four cycles
				if (run_len > 4)
					check_value("core_reset_n", 128'(core_reset_n), 128'(0));
				run_len++;
			end else if (run_len != 0) begin
				check_value("fill length", 128'(run_len), 128'(FILL_LEN));
				run_len = 0;
				fill_runs++;
			end
			if (refresh) begin
				if (refresh_gap != 0)
					check_value("refresh spacing", 128'(refresh_gap), 128'(4));
				refresh_gap = 1;
			end else if (refresh_gap != 0) begin
				refresh_gap++;
			end
		end
	end

	initial begin
		cycles = 0;
		while (cycles < CYCLE_LIMIT) begin
			@(posedge clk_sys);
			cycles++;
		end
		errors++;
		$display("timeout: run did not finish within %0d cycles", CYCLE_LIMIT);
		$display("errors: %0d", errors);
		$display("tests failed");
		$finish;
	end

	// ========================================================================
	// Stimulus
	// ========================================================================
	initial begin
		seed = 32'h35d3;
		errors = 0;
		run_len = 0;
		fill_runs = 0;
		refresh_gap = 0;
		RESET = 1'b1;
		ioctl_download = 1'b0;
		ioctl_index = 8'h00;
		ioctl_addr = '0;
		ioctl_dout = '0;
		ioctl_wr = 1'b0;
		header_mode = MODE_AUTO;
		region_mode = 2'd2;
		wram_init = 2'd0;
		user_reset = 1'b0;
		autosave = 1'b0;
		osd_status = 1'b0;
		load_req = 1'b0;
		save_req = 1'b0;
		bsram_we = 1'b0;
		img_mounted = 1'b0;
		img_readonly = 1'b0;
		img_size = '0;
		sd_ack = 1'b0;

		repeat (4) @(posedge clk_sys);
		@(negedge clk_sys);
		check_value("sd_rd", 128'(sd_rd), 128'(0));
		check_value("sd_wr", 128'(sd_wr), 128'(0));
		check_value("fill_wr", 128'(fill_wr), 128'(0));
		check_value("gg_code[128]", 128'(gg_code[128]), 128'(0));
		check_value("bk_busy", 128'(bk_busy), 128'(0));
		check_value("core_reset_n", 128'(core_reset_n), 128'(0));
		@(posedge clk_sys);
		RESET <= 1'b0;

		// Cheat record of eight random words
		begin_download(IDX_CODE);
		for (int i = 0; i < 8; i++) begin
			cheat_w[i] = 16'($random(seed));
			drive_word(25'(2 * i), cheat_w[i]);
		end
		@(negedge clk_sys);
		check_value("gg_code[128]", 128'(gg_code[128]), 128'(1));
		check_value("gg_code", gg_code[127:0], {cheat_w[1], cheat_w[0], cheat_w[3],
			cheat_w[2], cheat_w[5], cheat_w[4], cheat_w[7], cheat_w[6]});
		@(negedge clk_sys);
		check_value("gg_code[128]", 128'(gg_code[128]), 128'(0));
		end_download();

		// Forced HiROM with sizes from the internal header
		@(posedge clk_sys);
		header_mode <= MODE_HIROM;
		wram_init   <= 2'd1;
		begin_download(IDX_CART);
		drive_word(25'd0, 16'($random(seed)));
		@(negedge clk_sys);
		check_value("rom_type", 128'(rom_type), 128'(8'd1));
		check_value("rom_mask", 128'(rom_mask), 128'(size_mask(4'hC)));
		check_value("ram_mask", 128'(ram_mask), 128'(0));
		drive_word(25'd2, 16'($random(seed)) | 16'h0100);
		drive_word(HDR_HIROM, 16'h0A00);
		drive_word(HDR_HIROM + 25'd2, 16'h0005);
		@(negedge clk_sys);
		check_value("rom_type", 128'(rom_type), 128'(8'd1));
		check_value("rom_mask", 128'(rom_mask), 128'(size_mask(4'hA)));
		check_value("ram_mask", 128'(ram_mask), 128'(size_mask(4'h5)));
		end_download();
		wait_fill_done();

		// Auto header with a writable image and the backup load
		@(posedge clk_sys);
		header_mode  <= MODE_AUTO;
		wram_init    <= 2'd0;
		img_mounted  <= 1'b1;
		img_size     <= 64'h2000;
		autosave     <= 1'b1;
		begin_download(IDX_CART);
		@(posedge clk_sys);
		region_mode <= 2'd0;
		drive_word(25'd0, 16'h213B);
		@(negedge clk_sys);
		check_value("rom_type", 128'(rom_type), 128'(8'h21));
		check_value("rom_mask", 128'(rom_mask), 128'(size_mask(4'hB)));
		check_value("ram_mask", 128'(ram_mask), 128'(24'h1FFF));
		word2 = 16'($random(seed)) & 16'hFEFF;
		drive_word(25'd2, word2);
		// Region flag is already latched, pal must still hold
		repeat (2) @(negedge clk_sys);
		check_value("pal", 128'(pal), 128'(1));
		end_download();
		repeat (2) @(negedge clk_sys);
		check_value("pal", 128'(pal), 128'(word2[8]));
		check_value("bk_ena", 128'(bk_ena), 128'(1));
		wait_backup_done();
		check_sectors(1'b0);

		// Pending save and autosave when the OSD opens
		@(posedge clk_sys);
		bsram_we <= 1'b1;
		@(posedge clk_sys);
		bsram_we <= 1'b0;
		@(negedge clk_sys);
		check_value("bk_pending", 128'(bk_pending), 128'(1));
		check_value("led_user", 128'(led_user), 128'(1));
		@(posedge clk_sys);
		osd_status <= 1'b1;
		wait_backup_done();
		check_sectors(1'b1);
		check_value("bk_pending", 128'(bk_pending), 128'(0));
		check_value("led_user", 128'(led_user), 128'(0));
		@(posedge clk_sys);
		osd_status <= 1'b0;
		wait_fill_done();

		// Remaining fill patterns and the forced regions
		for (int m = 2; m < 4; m++) begin
			@(posedge clk_sys);
			img_mounted <= 1'b0;
			wram_init   <= 2'(m);
			region_mode <= 2'(5 - m);
			begin_download(IDX_CART);
			repeat (2) @(posedge clk_sys);
			end_download();
			wait_fill_done();
			check_value("pal", 128'(pal), 128'(1));
			check_value("bk_ena", 128'(bk_ena), 128'(0));
		end

		// Core reset releases within four cycles once the clear ends
		repeat (4) @(negedge clk_sys);
		check_value("core_reset_n", 128'(core_reset_n), 128'(1));
		check_value("refresh running", 128'(refresh_gap > 0 && refresh_gap <= 4), 128'(1));
		check_value("fill runs", 128'(fill_runs), 128'(4));

		$display("errors: %0d", errors);
		if (errors == 0)
			$display("all tests passed");
		else
			$display("tests failed");
		$finish;
	end

endmodule

// File: verilog.f
hw/snes_loader_pkg.sv
hw/ioctl_if.sv
hw/cart_header_decode.sv
hw/cheat_code_assembler.sv
hw/wram_clear_seq.sv
hw/backup_sector_seq.sv
hw/core_reset_gen.sv
hw/snes_loader_top.sv
test/tb_snes_loader.sv
